//--- logic/nabp_cfg.svh
`ifndef NABP_CFG_SVH
`define NABP_CFG_SVH

// ------------------------------------------------------------
// sizes of the processing stage
// ------------------------------------------------------------

// angle index, 256 codes over 180 degrees
`define NABP_ANGLE_W 8

// filtered sample, signed
`define NABP_DATA_W 12

// filtered RAM address (s value), signed
`define NABP_S_W 12

// taps per projection line
`define NABP_PARTITIONS 4

// lines per angle
`define NABP_LINES 4

// cycles one shift holds pe_en
`define NABP_SHIFT_CYCLES 8

`endif

//--- logic/nabp_pkg.sv
`include "nabp_cfg.svh"

package nabp_pkg;

    // angle split into quadrant and offset within it
    typedef struct packed {
        logic [1:0]                quadrant;
        logic [`NABP_ANGLE_W-3:0]  offset;
    } angle_parts_t;

    // raw index for the lookup, parts for the scan decode
    typedef union packed {
        logic [`NABP_ANGLE_W-1:0]  raw;
        angle_parts_t              parts;
    } angle_word_u;

    // map and shift accumulators share the RAM address width
    typedef logic signed [`NABP_S_W-1:0] accu_t;

    typedef enum logic {
        scan_x,
        scan_y
    } scan_mode_e;

    typedef enum logic {
        forward,
        reverse
    } scan_dir_e;

    // swap controller states
    typedef enum logic [3:0] {
        ready,
        setup_1,
        setup_2,
        setup_3,
        fill,
        fill_and_shift,
        angle_setup_1,
        angle_setup_2,
        angle_setup_3,
        shift
    } ctrl_state_e;

endpackage

//--- logic/swap_if.sv
`timescale 1ns/1ns

interface swap_if;
    import nabp_pkg::*;

    // line start, map step and tap step from the controller
    accu_t accu_init;
    accu_t accu_base;
    accu_t sh_base;

    // acks, one cycle each, only while the request is up
    logic  swap_ack;
    logic  next_itr_ack;

    // unit requests
    // swap: fill done, taps ready to shift
    logic  swap;
    // next_itr: unit idle, can take a new line
    logic  next_itr;

    modport control
    (
        output accu_init,
        output accu_base,
        output sh_base,
        output swap_ack,
        output next_itr_ack,
        input  swap,
        input  next_itr
    );

    modport unit
    (
        input  accu_init,
        input  accu_base,
        input  sh_base,
        input  swap_ack,
        input  next_itr_ack,
        output swap,
        output next_itr
    );

endinterface

//--- logic/angle_lut.sv
`timescale 1ns/1ns

`include "nabp_cfg.svh"

module angle_lut
(
    input  logic                  clk,
    input  nabp_pkg::angle_word_u angle,
    output nabp_pkg::accu_t       map_part,
    output nabp_pkg::accu_t       map_base,
    output nabp_pkg::accu_t       shift_base
);
    import nabp_pkg::*;

    // ------------------------------------------------------------
    // table, one registered cycle from angle to values
    // ------------------------------------------------------------
    // values follow the angle while it is held, so the
    // controller reads them from the first setup cycle on

    always_ff @(posedge clk)
    begin
        // start of the map accumulator, angle times four
        map_part <= accu_t'(angle.raw) <<< 2;

        // map step per line
        // low nibble of the angle, never zero
        map_base <= accu_t'(angle.raw[3:0]) + accu_t'(1);

        // tap step within a line
        // top two bits of the angle, never zero
        shift_base <= accu_t'(angle.raw[`NABP_ANGLE_W-1 -: 2]) + accu_t'(1);
    end

endmodule

//--- logic/swap_control.sv
`timescale 1ns/1ns

`include "nabp_cfg.svh"

module swap_control
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic            fr_has_next_angle,
    input  logic            fr_next_angle_ack,
    input  nabp_pkg::accu_t map_part,
    input  nabp_pkg::accu_t map_base,
    input  nabp_pkg::accu_t shift_base,
    swap_if.control         sw [2],
    output logic            fr_next_angle,
    output logic            sw_sel,
    output logic            pe_kick,
    output logic            pe_reset
);
    import nabp_pkg::*;

    // reaches LINES once every line of the angle is swapped
    localparam int LINE_W = $clog2(`NABP_LINES + 1);

    ctrl_state_e       state;
    ctrl_state_e       next_state;
    logic [LINE_W-1:0] line_cnt;
    accu_t             accu;

    logic in_setup;
    logic has_next_line;
    logic lines_done;
    logic swa_swap;
    logic swa_next_itr;
    logic swb_next_itr;
    logic swa_next_itr_ack;
    logic swb_next_itr_ack;
    logic swap_ack;

    // ------------------------------------------------------------
    // unit roles
    // ------------------------------------------------------------
    // unit a fills while unit b shifts
    // sw_sel low makes unit 0 a and unit 1 b
    assign swa_swap     = sw_sel ? sw[1].swap : sw[0].swap;
    assign swa_next_itr = sw_sel ? sw[1].next_itr : sw[0].next_itr;
    assign swb_next_itr = sw_sel ? sw[0].next_itr : sw[1].next_itr;

    // swap_ack only ever goes to the filling unit
    assign sw[0].swap_ack     = swap_ack & ~sw_sel;
    assign sw[1].swap_ack     = swap_ack & sw_sel;
    assign sw[0].next_itr_ack = sw_sel ? swb_next_itr_ack : swa_next_itr_ack;
    assign sw[1].next_itr_ack = sw_sel ? swa_next_itr_ack : swb_next_itr_ack;

    // both units see the same accumulator and steps
    for (genvar i = 0; i < 2; i++)
    begin : g_share
        assign sw[i].accu_init = accu;
        assign sw[i].accu_base = map_base;
        assign sw[i].sh_base   = shift_base;
    end

    // ------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------
    assign in_setup = state inside {setup_1, setup_2, setup_3,
                                    angle_setup_1, angle_setup_2, angle_setup_3};
    assign has_next_line = line_cnt < LINE_W'(`NABP_LINES - 1);
    assign lines_done    = line_cnt == LINE_W'(`NABP_LINES);

    // unit a takes the first line of an angle
    assign swa_next_itr_ack = (state == setup_3) || (state == angle_setup_3);

    // swap once a is full and b has finished any shift
    assign swap_ack = swa_swap &&
                      ((state == fill) || (state == fill_and_shift && swb_next_itr));

    // the unit just released by the shift takes the next line
    assign swb_next_itr_ack = swap_ack && has_next_line;

    // new angle only once the last line has left the fill side
    assign fr_next_angle = fr_has_next_angle &&
                           ((state == ready) ||
                            (state == fill_and_shift && lines_done));

    assign pe_kick  = swap_ack;
    assign pe_reset = (state == setup_3);

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            ready:
                if (fr_next_angle_ack)
                    next_state = setup_1;
            setup_1:
                next_state = setup_2;
            setup_2:
                next_state = setup_3;
            setup_3:
                next_state = fill;
            fill:
                if (swap_ack)
                    next_state = fill_and_shift;
            fill_and_shift:
                if (lines_done)
                begin
                    // last line is shifting so wait for the next angle or the end
                    if (!fr_has_next_angle)
                        next_state = shift;
                    else if (fr_next_angle_ack)
                        next_state = angle_setup_1;
                end
            angle_setup_1:
                next_state = angle_setup_2;
            angle_setup_2:
                next_state = angle_setup_3;
            angle_setup_3:
                next_state = fill_and_shift;
            shift:
                if (swb_next_itr)
                    next_state = ready;
            default:
                next_state = ready;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state    <= ready;
            sw_sel   <= 1'b0;
            line_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            if (swap_ack)
                sw_sel <= ~sw_sel;
            if (in_setup)
                line_cnt <= '0;
            else if (swap_ack)
                line_cnt <= line_cnt + 1'b1;
        end
    end

    // table values are valid from setup_1 and load one cycle later
    // each swap moves the start down one map step for the next line
    always_ff @(posedge clk)
    begin
        if (state == setup_2 || state == angle_setup_2)
            accu <= map_part;
        else if (swap_ack)
            accu <= accu - map_base;
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // kicks go only to a unit that asks for a new line
    a_kick_has_req: assert property (@(posedge clk) disable iff (!reset_n)
        (!swa_next_itr_ack || swa_next_itr) && (!swb_next_itr_ack || swb_next_itr));

    // request held across a slow source
    a_req_held: assert property (@(posedge clk) disable iff (!reset_n)
        fr_next_angle && !fr_next_angle_ack |=> fr_next_angle);

    a_ack_has_req: assert property (@(posedge clk) disable iff (!reset_n)
        fr_next_angle_ack |-> fr_next_angle);

endmodule

//--- logic/swappable.sv
`timescale 1ns/1ns

`include "nabp_cfg.svh"

module swappable
(
    input  logic                                       clk,
    input  logic                                       reset_n,
    swap_if.unit                                       ctl,
    input  logic signed [`NABP_DATA_W-1:0]             fr_val,
    output nabp_pkg::accu_t                            fr_s_val,
    output logic [`NABP_PARTITIONS-1:0][`NABP_DATA_W-1:0] taps,
    output logic                                       pe_en
);
    import nabp_pkg::*;

    localparam int K_W = $clog2(`NABP_PARTITIONS + 1);
    localparam int T_W = $clog2(`NABP_PARTITIONS);
    localparam int C_W = $clog2(`NABP_SHIFT_CYCLES);

    // unit states
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_fill  = 2'd1;
    localparam logic [1:0] st_full  = 2'd2;
    localparam logic [1:0] st_shift = 2'd3;

    logic [1:0]     state;
    logic [K_W-1:0] k;
    logic [C_W-1:0] shift_cnt;
    accu_t          offset;
    logic           issue;
    logic           rd_valid;
    logic [T_W-1:0] rd_idx;

    // one address per tap, k runs one past the last tap to drain
    assign issue    = (state == st_fill) && (k < K_W'(`NABP_PARTITIONS));
    // accu_init holds still while this unit fills
    assign fr_s_val = ctl.accu_init + offset;

    assign ctl.next_itr = (state == st_idle);
    assign ctl.swap     = (state == st_full);
    assign pe_en        = (state == st_shift);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state     <= st_idle;
            k         <= '0;
            shift_cnt <= '0;
            rd_valid  <= 1'b0;
        end
        else
        begin
            rd_valid <= issue;
            case (state)
                st_idle:
                    if (ctl.next_itr_ack)
                    begin
                        state <= st_fill;
                        k     <= '0;
                    end
                st_fill:
                begin
                    if (issue)
                        k <= k + 1'b1;
                    // last sample lands at the end of this cycle
                    if (k == K_W'(`NABP_PARTITIONS))
                        state <= st_full;
                end
                st_full:
                    if (ctl.swap_ack)
                    begin
                        state     <= st_shift;
                        shift_cnt <= '0;
                    end
                default:
                begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == C_W'(`NABP_SHIFT_CYCLES - 1))
                        state <= st_idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // address generator and tap capture
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (state == st_idle)
            offset <= '0;
        else if (issue)
            offset <= offset + ctl.sh_base;
        // RAM answers one cycle after the address
        rd_idx <= T_W'(k);
        if (rd_valid)
            taps[rd_idx] <= fr_val;
    end

    a_kick_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
        ctl.next_itr_ack |-> state == st_idle);

    // start moves at most one map step between kick and first address
    a_start_step: assert property (@(posedge clk) disable iff (!reset_n)
        ctl.next_itr_ack |=> (ctl.accu_init == $past(ctl.accu_init)) ||
                             (ctl.accu_init == $past(ctl.accu_init) - ctl.accu_base));

endmodule

//--- logic/pe_output_stage.sv
`timescale 1ns/1ns

`include "nabp_cfg.svh"

module pe_output_stage
(
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       sw_sel,
    input  logic                                       pe_kick,
    input  nabp_pkg::angle_word_u                      fr_angle,
    input  logic [`NABP_PARTITIONS-1:0][`NABP_DATA_W-1:0] unit_taps [2],
    input  logic [1:0]                                 unit_pe_en,
    output logic [`NABP_PARTITIONS-1:0][`NABP_DATA_W-1:0] pe_taps,
    output logic                                       pe_en,
    output nabp_pkg::scan_mode_e                       pe_scan_mode,
    output nabp_pkg::scan_dir_e                        pe_scan_direction
);
    import nabp_pkg::*;

    // angle of the line now shifting
    angle_word_u pe_angle;

    // the unit not filling drives the PEs
    assign pe_taps = sw_sel ? unit_taps[0] : unit_taps[1];
    assign pe_en   = sw_sel ? unit_pe_en[0] : unit_pe_en[1];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pe_angle <= '0;
        else if (pe_kick)
            pe_angle <= fr_angle;
    end

    // x scan near the horizontal, quadrants 0 and 3
    assign pe_scan_mode = (pe_angle.parts.quadrant == 2'd0 ||
                           pe_angle.parts.quadrant == 2'd3) ? scan_x : scan_y;

    // reverse past 90 degrees
    assign pe_scan_direction = pe_angle.parts.quadrant[1] ? reverse : forward;

endmodule

//--- logic/nabp_processing.sv
`timescale 1ns/1ns

`include "nabp_cfg.svh"

module nabp_processing
(
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic [`NABP_ANGLE_W-1:0]                   fr_angle,
    input  logic                                       fr_has_next_angle,
    input  logic                                       fr_next_angle_ack,
    input  logic signed [`NABP_DATA_W-1:0]             fr0_val,
    input  logic signed [`NABP_DATA_W-1:0]             fr1_val,
    output logic                                       pe_reset,
    output logic                                       pe_kick,
    output logic                                       pe_en,
    output nabp_pkg::scan_mode_e                       pe_scan_mode,
    output nabp_pkg::scan_dir_e                        pe_scan_direction,
    output logic [`NABP_PARTITIONS-1:0][`NABP_DATA_W-1:0] pe_taps,
    output logic                                       fr_next_angle,
    output logic signed [`NABP_S_W-1:0]                fr0_s_val,
    output logic signed [`NABP_S_W-1:0]                fr1_s_val
);
    import nabp_pkg::*;

    accu_t                                        map_part;
    accu_t                                        map_base;
    accu_t                                        shift_base;
    logic                                         sw_sel;
    logic signed [`NABP_DATA_W-1:0]               unit_fr_val [2];
    accu_t                                        unit_fr_s_val [2];
    logic [`NABP_PARTITIONS-1:0][`NABP_DATA_W-1:0] unit_taps [2];
    logic [1:0]                                   unit_pe_en;

    swap_if sw [2] ();

    // each unit owns one RAM port
    assign unit_fr_val[0] = fr0_val;
    assign unit_fr_val[1] = fr1_val;
    assign fr0_s_val      = unit_fr_s_val[0];
    assign fr1_s_val      = unit_fr_s_val[1];

    angle_lut angle_lut_i
    (
        .clk        (clk),
        .angle      (fr_angle),
        .map_part   (map_part),
        .map_base   (map_base),
        .shift_base (shift_base)
    );

    swap_control swap_control_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .fr_has_next_angle (fr_has_next_angle),
        .fr_next_angle_ack (fr_next_angle_ack),
        .map_part          (map_part),
        .map_base          (map_base),
        .shift_base        (shift_base),
        .sw                (sw),
        .fr_next_angle     (fr_next_angle),
        .sw_sel            (sw_sel),
        .pe_kick           (pe_kick),
        .pe_reset          (pe_reset)
    );

    // two identical fill/shift units
    for (genvar i = 0; i < 2; i++)
    begin : g_unit
        swappable swappable_i
        (
            .clk      (clk),
            .reset_n  (reset_n),
            .ctl      (sw[i]),
            .fr_val   (unit_fr_val[i]),
            .fr_s_val (unit_fr_s_val[i]),
            .taps     (unit_taps[i]),
            .pe_en    (unit_pe_en[i])
        );
    end

    pe_output_stage pe_output_stage_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .sw_sel            (sw_sel),
        .pe_kick           (pe_kick),
        .fr_angle          (fr_angle),
        .unit_taps         (unit_taps),
        .unit_pe_en        (unit_pe_en),
        .pe_taps           (pe_taps),
        .pe_en             (pe_en),
        .pe_scan_mode      (pe_scan_mode),
        .pe_scan_direction (pe_scan_direction)
    );

endmodule

//--- test/nabp_processing_tb.sv
`timescale 1ns/1ns

`include "nabp_cfg.svh"

module nabp_processing_tb;

    localparam int          MAX_VECTORS   = 64;
    localparam int          WAIT_LIMIT    = 500;
    localparam int          MAX_ACK_DELAY = 5;
    localparam logic [31:0] SEED          = 32'haf90_926b;

    // DUT inputs
    logic                                          clk = 1'b0;
    logic                                          reset_n;
    logic [`NABP_ANGLE_W-1:0]                      fr_angle;
    logic                                          fr_has_next_angle;
    logic                                          fr_next_angle_ack;
    logic signed [`NABP_DATA_W-1:0]                fr0_val = '0;
    logic signed [`NABP_DATA_W-1:0]                fr1_val = '0;

    // DUT outputs
    logic                                          pe_reset;
    logic                                          pe_kick;
    logic                                          pe_en;
    logic                                          pe_scan_mode;
    logic                                          pe_scan_direction;
    logic [`NABP_PARTITIONS-1:0][`NABP_DATA_W-1:0] pe_taps;
    logic                                          fr_next_angle;
    logic signed [`NABP_S_W-1:0]                   fr0_s_val;
    logic signed [`NABP_S_W-1:0]                   fr1_s_val;

    // vectors from the file
    logic [`NABP_ANGLE_W-1:0] vec_angle [MAX_VECTORS];
    logic                     vec_mode [MAX_VECTORS];
    logic                     vec_dir [MAX_VECTORS];
    int                       n_vec = 0;

    // monitor state is only written on the falling edge
    int kick_count    = 0;
    int shift_left    = 0;
    int reset_count   = 0;
    int scan_idx      = -1;
    int line_angle    = 0;
    int line_idx      = 0;
    int stream_errors = 0;

    // main sequence state
    int          value_errors = 0;
    int          flow_errors  = 0;
    logic        timed_out    = 1'b0;
    int          i;

    nabp_processing nabp_processing_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .fr_angle          (fr_angle),
        .fr_has_next_angle (fr_has_next_angle),
        .fr_next_angle_ack (fr_next_angle_ack),
        .fr0_val           (fr0_val),
        .fr1_val           (fr1_val),
        .pe_reset          (pe_reset),
        .pe_kick           (pe_kick),
        .pe_en             (pe_en),
        .pe_scan_mode      (pe_scan_mode),
        .pe_scan_direction (pe_scan_direction),
        .pe_taps           (pe_taps),
        .fr_next_angle     (fr_next_angle),
        .fr0_s_val         (fr0_s_val),
        .fr1_s_val         (fr1_s_val)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ------------------------------------------------------------
    // filtered RAM model and reference
    // ------------------------------------------------------------
    // sample is the low 12 bits of address times 3 plus 5
    function automatic logic [`NABP_DATA_W-1:0] ram_word(input logic signed [`NABP_S_W-1:0] addr);
        int word;
        word = int'(addr) * 3 + 5;
        return word[`NABP_DATA_W-1:0];
    endfunction

    // line l starts at 4a minus l map steps
    // map step is the low nibble plus 1 and tap step the top bits plus 1
    function automatic logic [`NABP_DATA_W-1:0] expected_tap(input int angle, input int line,
                                                             input int k);
        int map_base;
        int shift_base;
        int addr;
        map_base   = (angle & 15) + 1;
        shift_base = (angle >> (`NABP_ANGLE_W - 2)) + 1;
        addr       = 4 * angle - line * map_base + k * shift_base;
        return ram_word(addr[`NABP_S_W-1:0]);
    endfunction

    // answers one cycle after each address
    always @(posedge clk)
    begin
        fr0_val <= ram_word(fr0_s_val);
        fr1_val <= ram_word(fr1_s_val);
    end

    // ------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------
    task automatic report_mismatch(input string sig, input int expected, input int actual);
        $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, sig, expected, actual);
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t ns: %s", $time, what);
    endtask

    // ------------------------------------------------------------
    // output monitor
    // ------------------------------------------------------------
    task automatic check_taps(input int angle, input int line);
        logic [`NABP_DATA_W-1:0] expected;
        int                      k;
        for (k = 0; k < `NABP_PARTITIONS; k++)
        begin
            expected = expected_tap(angle, line, k);
            assert (pe_taps[k] == expected)
            else
            begin
                stream_errors++;
                report_mismatch($sformatf("pe_taps[%0d]", k), int'(expected), int'(pe_taps[k]));
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (reset_n)
        begin
            // scan controls belong to the last kicked line
            if (scan_idx >= 0)
            begin
                assert (pe_scan_mode == vec_mode[scan_idx])
                else
                begin
                    stream_errors++;
                    report_mismatch("pe_scan_mode", vec_mode[scan_idx], pe_scan_mode);
                end
                assert (pe_scan_direction == vec_dir[scan_idx])
                else
                begin
                    stream_errors++;
                    report_mismatch("pe_scan_direction", vec_dir[scan_idx], pe_scan_direction);
                end
            end
            if (pe_reset)
            begin
                reset_count++;
                assert (kick_count == 0)
                else
                begin
                    stream_errors++;
                    report_failure("pe_reset came after lines were already kicked");
                end
            end
            if (pe_kick)
            begin
                assert (shift_left == 0)
                else
                begin
                    stream_errors++;
                    report_failure("pe_kick came before the previous shift ended");
                end
                assert (!pe_en)
                else
                begin
                    stream_errors++;
                    report_mismatch("pe_en", 0, 1);
                end
                // lines arrive in order with LINES per angle
                if (kick_count < n_vec * `NABP_LINES)
                begin
                    line_angle = int'(vec_angle[kick_count / `NABP_LINES]);
                    line_idx   = kick_count % `NABP_LINES;
                    scan_idx   = kick_count / `NABP_LINES;
                end
                else
                begin
                    stream_errors++;
                    report_failure("pe_kick came after the last line of the last angle");
                end
                kick_count++;
                shift_left = `NABP_SHIFT_CYCLES;
            end
            else if (shift_left > 0)
            begin
                assert (pe_en)
                else
                begin
                    stream_errors++;
                    report_mismatch("pe_en", 1, 0);
                end
                check_taps(line_angle, line_idx);
                shift_left--;
            end
            else
            begin
                assert (!pe_en)
                else
                begin
                    stream_errors++;
                    report_mismatch("pe_en", 0, 1);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // vector file and angle source
    // ------------------------------------------------------------
    task automatic read_vectors();
        int    fd;
        int    angle;
        int    mode;
        int    dir;
        string text;
        fd = $fopen("test/nabp_vectors.txt", "r");
        if (fd == 0)
        begin
            flow_errors++;
            report_failure("cannot open test/nabp_vectors.txt");
        end
        else
        begin
            while (!$feof(fd) && n_vec < MAX_VECTORS)
            begin
                if ($fgets(text, fd) == 0)
                    break;
                // comment lines do not scan as three fields
                if ($sscanf(text, "%h %d %d", angle, mode, dir) == 3)
                begin
                    vec_angle[n_vec] = angle[`NABP_ANGLE_W-1:0];
                    vec_mode[n_vec]  = mode[0];
                    vec_dir[n_vec]   = dir[0];
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_request(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!fr_next_angle && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!fr_next_angle)
        begin
            timed_out = 1'b1;
            flow_errors++;
            report_failure($sformatf("fr_next_angle never rose for angle %0d", idx));
        end
    endtask

    // request has to hold through a random ack delay
    task automatic send_angle(input int idx);
        int unsigned delay;
        int unsigned d;
        delay = $urandom % (MAX_ACK_DELAY + 1);
        for (d = 0; d < delay; d++)
        begin
            @(negedge clk);
            assert (fr_next_angle)
            else
            begin
                flow_errors++;
                report_failure("fr_next_angle dropped before its ack");
            end
        end
        @(posedge clk);
        // all lines of the previous angles are kicked by now
        assert (kick_count == idx * `NABP_LINES)
        else
        begin
            value_errors++;
            report_mismatch("pe_kick count", idx * `NABP_LINES, kick_count);
        end
        fr_angle          <= vec_angle[idx];
        fr_next_angle_ack <= 1'b1;
        @(posedge clk);
        fr_next_angle_ack <= 1'b0;
        fr_has_next_angle <= (idx + 1 < n_vec);
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while ((kick_count < n_vec * `NABP_LINES || shift_left > 0) && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (kick_count < n_vec * `NABP_LINES || shift_left > 0)
        begin
            timed_out = 1'b1;
            flow_errors++;
            report_failure("the last lines were never shifted out");
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial
    begin
        reset_n           = 1'b0;
        fr_angle          = '0;
        fr_has_next_angle = 1'b0;
        fr_next_angle_ack = 1'b0;
        void'($urandom(SEED));

        read_vectors();
        if (n_vec == 0)
        begin
            flow_errors++;
            report_failure("no vectors were read");
        end

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        // idle outputs once out of reset
        @(negedge clk);
        assert (!pe_en)
        else
        begin
            value_errors++;
            report_mismatch("pe_en", 0, 1);
        end
        assert (!pe_kick)
        else
        begin
            value_errors++;
            report_mismatch("pe_kick", 0, 1);
        end
        assert (!pe_reset)
        else
        begin
            value_errors++;
            report_mismatch("pe_reset", 0, 1);
        end
        assert (!fr_next_angle)
        else
        begin
            value_errors++;
            report_mismatch("fr_next_angle", 0, 1);
        end

        @(posedge clk);
        fr_has_next_angle <= (n_vec > 0);
        for (i = 0; i < n_vec && !timed_out; i++)
        begin
            wait_request(i);
            if (!timed_out)
                send_angle(i);
        end
        if (!timed_out)
            wait_for_drain();

        repeat (2) @(posedge clk);
        if (!timed_out)
        begin
            assert (kick_count == n_vec * `NABP_LINES)
            else
            begin
                value_errors++;
                report_mismatch("pe_kick total", n_vec * `NABP_LINES, kick_count);
            end
            // one start from ready for the whole run
            assert (reset_count == 1)
            else
            begin
                value_errors++;
                report_mismatch("pe_reset count", 1, reset_count);
            end
            assert (!fr_next_angle)
            else
            begin
                value_errors++;
                report_mismatch("fr_next_angle", 0, 1);
            end
        end

        $display("errors: %0d value, %0d output stream, %0d handshake or timeout",
                 value_errors, stream_errors, flow_errors);
        if (value_errors + stream_errors + flow_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/nabp_pkg.sv
logic/swap_if.sv
logic/angle_lut.sv
logic/swap_control.sv
logic/swappable.sv
logic/pe_output_stage.sv
logic/nabp_processing.sv
test/nabp_processing_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the processing stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f project.f \
    --top-module nabp_processing_tb \
    --Mdir "$BUILD" -o nabp_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/nabp_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- test/nabp_vectors.txt
// angle (hex), expected scan mode (0 x, 1 y), expected scan direction (0 forward, 1 reverse)
// quadrant is angle[7:6], the order walks all four quadrants in turn
00 0 0
40 1 0
80 1 1
c0 0 1
05 0 0
4a 1 0
91 1 1
d3 0 1
1f 0 0
63 1 0
a7 1 1
ee 0 1
3f 0 0
7f 1 0
bf 1 1
ff 0 1
